// File: Makefile
# Verilator build and run of the EX stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_ex_stage
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) rtl/*.sv test/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_wb_ctrl.sv
rtl/ex_stage.sv
test/tb_ex_stage.sv

// File: rtl/ex_alu.sv
`timescale 1ns/100ps

module ex_alu (
  input  ex_pkg::alu_req_t        alu_req_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    cmp_result_o
);

  import ex_pkg::*;

  // Operand shorthands
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  // Shift amount from the low bits of b
  logic [4:0]      shamt;

  // Arithmetic results
  logic [XLEN-1:0] add_res;
  logic [XLEN-1:0] sub_res;
  // Shifter results
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;

  // Comparator flags
  logic            is_equal;
  logic            is_lt_signed;
  logic            is_lt_unsigned;

  assign op_a  = alu_req_i.operand_a;
  assign op_b  = alu_req_i.operand_b;
  assign shamt = op_b[4:0];

  //////////////////////////////
  // Datapath
  //////////////////////////////

  assign add_res = op_a + op_b;
  assign sub_res = op_a - op_b;

  assign sll_res = op_a << shamt;
  assign srl_res = op_a >> shamt;
  // Arithmetic shift keeps the sign of a
  assign sra_res = $signed(op_a) >>> shamt;

  assign is_equal       = (op_a == op_b);
  assign is_lt_signed   = ($signed(op_a) < $signed(op_b));
  assign is_lt_unsigned = (op_a < op_b);

  //////////////////////////////
  // Comparison output
  //////////////////////////////

  // Branch decision for the compare operators only
  always_comb begin
    cmp_result_o = 1'b0;
    case (alu_req_i.op)
      ALU_EQ:   cmp_result_o = is_equal;
      ALU_NE:   cmp_result_o = ~is_equal;
      ALU_SLT:  cmp_result_o = is_lt_signed;
      ALU_SLTU: cmp_result_o = is_lt_unsigned;
      default:  cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    result_o = '0;
    case (alu_req_i.op)
      ALU_ADD:  result_o = add_res;
      ALU_SUB:  result_o = sub_res;
      ALU_AND:  result_o = op_a & op_b;
      ALU_OR:   result_o = op_a | op_b;
      ALU_XOR:  result_o = op_a ^ op_b;
      ALU_SLL:  result_o = sll_res;
      ALU_SRL:  result_o = srl_res;
      ALU_SRA:  result_o = sra_res;
      // Compare operators give 0 or 1 in bit zero
      ALU_SLT,
      ALU_SLTU,
      ALU_EQ,
      ALU_NE:   result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
      // Unused encodings give zero
      default:  result_o = '0;
    endcase
  end

endmodule

// File: rtl/ex_mult.sv
`timescale 1ns/100ps

module ex_mult (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_pkg::mult_req_t       mult_req_i,
  input  logic                    ex_ready_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    ready_o,
  output logic                    multicycle_o
);

  import ex_pkg::*;

  // Idle, then done while the high half is presented
  typedef enum logic {
    MULT_IDLE = 1'b0,
    MULT_DONE = 1'b1
  } mult_state_e;

  mult_state_e state_q;
  mult_state_e state_d;

  // Full signed product
  logic signed [2*XLEN-1:0] product;
  // High half kept for the second cycle
  logic [XLEN-1:0]          high_q;
  // New MULH request seen while idle
  logic                     mulh_start;

  assign product = $signed(mult_req_i.operand_a) * $signed(mult_req_i.operand_b);

  assign mulh_start = (state_q == MULT_IDLE) & mult_req_i.en & (mult_req_i.op == MULT_MULH);

  //////////////////////////////
  // MULH sequencing
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MULT_IDLE: begin
        // Stall one cycle to register the high half
        if (mulh_start) begin
          state_d = MULT_DONE;
        end
      end
      MULT_DONE: begin
        // Leave only once the stage moves on
        if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end
      default: state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload register, loaded on the accept cycle only
  always_ff @(posedge clk) begin
    if (mulh_start) begin
      high_q <= product[2*XLEN-1:XLEN];
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // Low half goes out at once, high half from the register
  assign result_o     = (state_q == MULT_DONE) ? high_q : product[XLEN-1:0];
  assign ready_o      = ~mulh_start;
  assign multicycle_o = (state_q == MULT_DONE);

endmodule

// File: rtl/ex_pkg.sv
package ex_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Data word of the core
  localparam int unsigned XLEN       = 32;
  // Register index including the upper bank bit
  localparam int unsigned REG_ADDR_W = 6;
  // Operator field widths
  localparam int unsigned ALU_OP_W   = 4;
  localparam int unsigned MULT_OP_W  = 1;

  //////////////////////////////
  // Operator encodings
  //////////////////////////////

  // ALU operators
  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB
  } alu_op_e;

  // Multiplier operators
  typedef enum logic [MULT_OP_W-1:0] {
    MULT_MUL  = 1'b0,
    MULT_MULH = 1'b1
  } mult_op_e;

  //////////////////////////////
  // Request and port bundles
  //////////////////////////////

  // ALU request from decode
  typedef struct packed {
    logic            en;
    alu_op_e         op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    // Jump target, passed on to fetch
    logic [XLEN-1:0] operand_c;
  } alu_req_t;

  // Multiplier request from decode
  typedef struct packed {
    logic            en;
    mult_op_e        op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } mult_req_t;

  // Register file write port
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } rf_wr_t;

endpackage

// File: rtl/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  // Unit requests from decode
  input  ex_pkg::alu_req_t              alu_req_i,
  input  ex_pkg::mult_req_t             mult_req_i,
  input  logic                          csr_access_i,
  input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,
  // Write destinations
  input  logic                          regfile_alu_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_i,
  // LSU
  input  logic                          lsu_en_i,
  input  logic [ex_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                          lsu_ready_ex_i,
  input  logic                          lsu_err_i,
  // Stall control
  input  logic                          branch_in_ex_i,
  input  logic                          wb_ready_i,
  // Write ports
  output ex_pkg::rf_wr_t                fwd_port_o,
  output ex_pkg::rf_wr_t                wb_port_o,
  // Branch outcome to fetch
  output logic [ex_pkg::XLEN-1:0]       jump_target_o,
  output logic                          branch_decision_o,
  output logic                          mult_multicycle_o,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o
);

  import ex_pkg::*;

  logic [XLEN-1:0] alu_result;
  logic            alu_cmp_result;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;

  // Branch outcome straight from the ALU request
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_req_i.operand_c;

  ex_alu u_alu (
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // Stage ready lets a finished MULH retire
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_req_i   (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_wb_ctrl u_wb_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_req_i.en),
    .alu_result_i        (alu_result),
    .mult_en_i           (mult_req_i.en),
    .mult_result_i       (mult_result),
    .mult_ready_i        (mult_ready),
    .csr_access_i        (csr_access_i),
    .csr_rdata_i         (csr_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .lsu_en_i            (lsu_en_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .lsu_err_i           (lsu_err_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .wb_ready_i          (wb_ready_i),
    .fwd_port_o          (fwd_port_o),
    .wb_port_o           (wb_port_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

endmodule

// File: rtl/ex_wb_ctrl.sv
`timescale 1ns/100ps

module ex_wb_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  // Unit results
  input  logic                          alu_en_i,
  input  logic [ex_pkg::XLEN-1:0]       alu_result_i,
  input  logic                          mult_en_i,
  input  logic [ex_pkg::XLEN-1:0]       mult_result_i,
  input  logic                          mult_ready_i,
  input  logic                          csr_access_i,
  input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,
  // Destination of the forwarding port
  input  logic                          regfile_alu_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,
  // Destination of the load writeback
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_i,
  // LSU side
  input  logic                          lsu_en_i,
  input  logic [ex_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                          lsu_ready_ex_i,
  input  logic                          lsu_err_i,
  // Stall control
  input  logic                          branch_in_ex_i,
  input  logic                          wb_ready_i,
  output ex_pkg::rf_wr_t                fwd_port_o,
  output ex_pkg::rf_wr_t                wb_port_o,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o
);

  import ex_pkg::*;

  // EX/WB register contents
  logic                  wb_we_q;
  logic [REG_ADDR_W-1:0] wb_waddr_q;
  // Load write survives only without an LSU error
  logic                  wb_we_d;
  // All downstream units can accept
  logic                  units_ready;

  //////////////////////////////
  // Forwarding port
  //////////////////////////////

  // Later source wins, CSR data highest
  always_comb begin
    fwd_port_o.we    = regfile_alu_we_i;
    fwd_port_o.waddr = regfile_alu_waddr_i;
    fwd_port_o.wdata = '0;
    if (alu_en_i) begin
      fwd_port_o.wdata = alu_result_i;
    end
    if (mult_en_i) begin
      fwd_port_o.wdata = mult_result_i;
    end
    if (csr_access_i) begin
      fwd_port_o.wdata = csr_rdata_i;
    end
  end

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  assign wb_we_d = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q    <= 1'b0;
      wb_waddr_q <= '0;
    end else if (ex_valid_o) begin
      wb_we_q <= wb_we_d;
      // Address kept from the last real write
      if (wb_we_d) begin
        wb_waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Nothing new, so flush the slot
      wb_we_q <= 1'b0;
    end
  end

  // Load data arrives from the LSU in the writeback cycle
  assign wb_port_o = '{we: wb_we_q, waddr: wb_waddr_q, wdata: lsu_rdata_i};

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // A branch finishes in EX and frees the stage
  assign ex_ready_o = units_ready | branch_in_ex_i;
  // Valid independent of ready
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

// File: test/ex_trace.txt
# kind(0 trace,1 random,2 mulh) alu_en op a b mult_en mult_op csr csr_rdata alu_we alu_waddr we waddr
# lsu_en lsu_rdy lsu_err branch wb_rdy | exp wdata br wb_we wb_waddr valid ready
0 1 0 00000005 00000003 0 0 0 00000000 1 05 0 00 0 1 0 0 1 00000008 0 0 00 1 1
0 1 1 00000003 00000005 0 0 0 00000000 1 06 0 00 0 1 0 0 1 fffffffe 0 0 00 1 1
0 1 2 f0f0f0f0 0ff00ff0 0 0 0 00000000 1 07 0 00 0 1 0 0 1 00f000f0 0 0 00 1 1
0 1 3 f0f0f0f0 0ff00ff0 0 0 0 00000000 1 08 0 00 0 1 0 0 1 fff0fff0 0 0 00 1 1
0 1 4 f0f0f0f0 0ff00ff0 0 0 0 00000000 1 09 0 00 0 1 0 0 1 ff00ff00 0 0 00 1 1
0 1 5 00000001 00000024 0 0 0 00000000 1 0a 0 00 0 1 0 0 1 00000010 0 0 00 1 1
0 1 6 80000000 0000001f 0 0 0 00000000 1 0b 0 00 0 1 0 0 1 00000001 0 0 00 1 1
0 1 7 80000000 00000004 0 0 0 00000000 1 0c 0 00 0 1 0 0 1 f8000000 0 0 00 1 1
0 1 8 ffffffff 00000001 0 0 0 00000000 1 0d 0 00 0 1 0 1 1 00000001 1 0 00 1 1
0 1 9 ffffffff 00000001 0 0 0 00000000 1 0e 0 00 0 1 0 1 1 00000000 0 0 00 1 1
0 1 a 12345678 12345678 0 0 0 00000000 0 00 0 00 0 1 0 1 1 00000001 1 0 00 1 1
0 1 b 12345678 12345679 0 0 0 00000000 0 00 0 00 0 1 0 1 1 00000001 1 0 00 1 1
0 1 a 00000001 00000002 0 0 0 00000000 0 00 0 00 0 0 0 1 1 00000000 0 0 00 0 1
1 1 0 00000000 00000000 0 0 0 00000000 1 11 0 00 0 1 0 0 1 00000000 0 0 00 1 1
1 1 1 00000000 00000000 0 0 0 00000000 1 12 0 00 0 1 0 0 1 00000000 0 0 00 1 1
1 1 5 00000000 00000000 0 0 0 00000000 1 13 0 00 0 1 0 0 1 00000000 0 0 00 1 1
1 1 6 00000000 00000000 0 0 0 00000000 1 14 0 00 0 1 0 0 1 00000000 0 0 00 1 1
1 1 7 00000000 00000000 0 0 0 00000000 1 15 0 00 0 1 0 0 1 00000000 0 0 00 1 1
1 1 8 00000000 00000000 0 0 0 00000000 1 16 0 00 0 1 0 1 1 00000000 0 0 00 1 1
1 1 9 00000000 00000000 0 0 0 00000000 1 17 0 00 0 1 0 1 1 00000000 0 0 00 1 1
1 0 0 00000000 00000000 1 0 0 00000000 1 18 0 00 0 1 0 0 1 00000000 0 0 00 1 1
0 0 0 00000007 fffffffd 1 0 0 00000000 1 19 0 00 0 1 0 0 1 ffffffeb 0 0 00 1 1
2 0 0 80000000 80000000 1 1 0 00000000 1 1a 0 00 0 1 0 0 1 40000000 0 0 00 1 1
2 0 0 ffffffff 00000002 1 1 0 00000000 1 1b 0 00 0 1 0 0 1 ffffffff 0 0 00 1 1
0 0 0 00000002 00000003 1 0 1 cafef00d 1 1c 0 00 0 1 0 0 1 cafef00d 0 0 00 1 1
0 1 0 00000002 00000003 0 0 1 0badf00d 1 1d 0 00 0 1 0 0 1 0badf00d 0 0 00 1 1
0 1 0 00000003 00000004 1 0 0 00000000 1 1e 0 00 0 1 0 0 1 0000000c 0 0 00 1 1
0 0 0 00000000 00000000 0 0 0 00000000 0 00 1 0a 1 1 0 0 1 00000000 0 1 0a 1 1
0 0 0 00000000 00000000 0 0 0 00000000 0 00 1 0b 1 1 1 0 1 00000000 0 0 0a 1 1
0 0 0 00000000 00000000 0 0 0 00000000 0 00 1 0c 1 1 0 0 1 00000000 0 1 0c 1 1
0 0 0 00000000 00000000 0 0 0 00000000 0 00 1 0d 1 1 0 0 0 00000000 0 1 0c 0 0
0 0 0 00000000 00000000 0 0 0 00000000 0 00 0 00 0 1 0 0 1 00000000 0 0 0c 0 1

// File: test/tb_ex_stage.sv
`timescale 1ns/100ps

module tb_ex_stage;

  import ex_pkg::*;

  logic                  clk;
  logic                  rst_n;
  alu_req_t              alu_req;
  mult_req_t             mult_req;
  logic                  csr_access;
  logic [XLEN-1:0]       csr_rdata;
  logic                  regfile_alu_we;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr;
  logic                  regfile_we;
  logic [REG_ADDR_W-1:0] regfile_waddr;
  logic                  lsu_en;
  logic [XLEN-1:0]       lsu_rdata;
  logic                  lsu_ready_ex;
  logic                  lsu_err;
  logic                  branch_in_ex;
  logic                  wb_ready;
  rf_wr_t                fwd_port;
  rf_wr_t                wb_port;
  logic [XLEN-1:0]       jump_target;
  logic                  branch_decision;
  logic                  mult_multicycle;
  logic                  ex_ready;
  logic                  ex_valid;

  integer                seed;
  int                    fd;
  int                    code;
  string                 line;
  // Fields of one trace line, order as in the trace header
  logic [31:0]           f [24];
  // EX/WB contents expected after the next edge
  logic                  pend_we;
  logic [REG_ADDR_W-1:0] pend_waddr;

  ex_stage dut (
    .clk (clk), .rst_n (rst_n),
    .alu_req_i (alu_req), .mult_req_i (mult_req),
    .csr_access_i (csr_access), .csr_rdata_i (csr_rdata),
    .regfile_alu_we_i (regfile_alu_we), .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i (regfile_we), .regfile_waddr_i (regfile_waddr),
    .lsu_en_i (lsu_en), .lsu_rdata_i (lsu_rdata),
    .lsu_ready_ex_i (lsu_ready_ex), .lsu_err_i (lsu_err),
    .branch_in_ex_i (branch_in_ex), .wb_ready_i (wb_ready),
    .fwd_port_o (fwd_port), .wb_port_o (wb_port),
    .jump_target_o (jump_target), .branch_decision_o (branch_decision),
    .mult_multicycle_o (mult_multicycle),
    .ex_ready_o (ex_ready), .ex_valid_o (ex_valid)
  );

  // 4 ns period
  always #2 clk = ~clk;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic cmp_model(input logic [3:0] op, input logic [31:0] a,
                                     input logic [31:0] b);
    case (alu_op_e'(op))
      ALU_EQ:   return a == b;
      ALU_NE:   return a != b;
      ALU_SLT:  return $signed(a) < $signed(b);
      ALU_SLTU: return a < b;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_model(input logic [3:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (alu_op_e'(op))
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return $signed(a) >>> b[4:0];
      // Compares put the flag in bit zero
      default: return {31'b0, cmp_model(op, a, b)};
    endcase
  endfunction

  function automatic logic [63:0] product_model(input logic [31:0] a, input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    return sa * sb;
  endfunction

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_hex(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("mismatch %s expected %h got %h", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // Drive one trace line, wait where needed, then compare
  task automatic run_vector();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_wd;
    logic        exp_br;
    logic [63:0] prod;
    int          waited;
    @(posedge clk);
    #0.5;
    a = f[3];
    b = f[4];
    // Kind 1 replaces the operands with generated ones
    if (f[0] == 32'h1) begin
      a = $random(seed);
      b = $random(seed);
    end
    alu_req = '{en: f[1][0], op: alu_op_e'(f[2][3:0]), operand_a: a, operand_b: b,
                operand_c: $random(seed)};
    mult_req = '{en: f[5][0], op: mult_op_e'(f[6][0]), operand_a: a, operand_b: b};
    csr_access        = f[7][0];
    csr_rdata         = f[8];
    regfile_alu_we    = f[9][0];
    regfile_alu_waddr = f[10][5:0];
    regfile_we        = f[11][0];
    regfile_waddr     = f[12][5:0];
    lsu_en            = f[13][0];
    lsu_ready_ex      = f[14][0];
    lsu_err           = f[15][0];
    branch_in_ex      = f[16][0];
    wb_ready          = f[17][0];
    lsu_rdata         = $random(seed);
    #1;
    // Writeback of the previous line
    check_hex("wb_port_o.we", 32'(pend_we), 32'(wb_port.we));
    check_hex("wb_port_o.waddr", 32'(pend_waddr), 32'(wb_port.waddr));
    check_hex("wb_port_o.wdata", lsu_rdata, wb_port.wdata);
    exp_wd = f[18];
    exp_br = f[19][0];
    if (f[0] == 32'h1) begin
      // Forwarding priority, later source wins
      exp_wd = '0;
      if (f[1][0]) exp_wd = alu_model(f[2][3:0], a, b);
      if (f[5][0]) begin
        prod   = product_model(a, b);
        exp_wd = prod[31:0];
      end
      if (f[7][0]) exp_wd = f[8];
      exp_br = cmp_model(f[2][3:0], a, b);
    end
    if (f[0] == 32'h2) begin
      // MULH stalls in its first cycle
      check_hex("ex_valid_o", 32'h0, 32'(ex_valid));
      check_hex("mult_multicycle_o", 32'h0, 32'(mult_multicycle));
      waited = 0;
      do begin
        @(posedge clk);
        #1.5;
        waited++;
      end while (!ex_valid && waited < 20);
      if (!ex_valid) stop_with_error("timeout while waiting for ex_valid_o after a MULH");
      if (waited != 1) stop_with_error("the MULH result did not arrive one cycle after the request");
      check_hex("mult_multicycle_o", 32'h1, 32'(mult_multicycle));
    end
    check_hex("fwd_port_o.wdata", exp_wd, fwd_port.wdata);
    check_hex("fwd_port_o.we", 32'(regfile_alu_we), 32'(fwd_port.we));
    check_hex("fwd_port_o.waddr", 32'(regfile_alu_waddr), 32'(fwd_port.waddr));
    check_hex("branch_decision_o", 32'(exp_br), 32'(branch_decision));
    check_hex("jump_target_o", alu_req.operand_c, jump_target);
    check_hex("ex_valid_o", 32'(f[22][0]), 32'(ex_valid));
    check_hex("ex_ready_o", 32'(f[23][0]), 32'(ex_ready));
    pend_we    = f[20][0];
    pend_waddr = f[21][5:0];
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed = 32'ha5d3;
    clk = 1'b0;
    rst_n = 1'b0;
    alu_req = '0;
    mult_req = '0;
    csr_access = 1'b0;
    csr_rdata = '0;
    regfile_alu_we = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we = 1'b0;
    regfile_waddr = '0;
    lsu_en = 1'b0;
    lsu_rdata = '0;
    lsu_ready_ex = 1'b1;
    lsu_err = 1'b0;
    branch_in_ex = 1'b0;
    wb_ready = 1'b1;
    pend_we = 1'b0;
    pend_waddr = '0;
    // Reset for 16 cycles, state checked throughout
    repeat (16) begin
      @(posedge clk);
      #1.5;
      check_hex("wb_port_o.we", 32'h0, 32'(wb_port.we));
      check_hex("mult_multicycle_o", 32'h0, 32'(mult_multicycle));
    end
    rst_n = 1'b1;
    #0.5;
    check_hex("wb_port_o.we", 32'h0, 32'(wb_port.we));
    check_hex("mult_multicycle_o", 32'h0, 32'(mult_multicycle));
    fd = $fopen("test/ex_trace.txt", "r");
    if (fd == 0) stop_with_error("cannot open the trace file test/ex_trace.txt");
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      // Skip blank and comment lines
      if (code > 1 && line[0] != "#") begin
        code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                       f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                       f[22], f[23]);
        if (code != 24) stop_with_error("a trace line does not hold 24 fields");
        run_vector();
      end
    end
    $fclose(fd);
    // One idle line flushes the last writeback check
    f = '{default: 32'h0};
    f[14] = 32'h1;
    f[17] = 32'h1;
    f[23] = 32'h1;
    run_vector();
    $display("Result: PASSED");
    $finish;
  end

endmodule
